// ==== kpb_config.svh ====
`ifndef KPB_CONFIG_SVH
`define KPB_CONFIG_SVH

// parameter and stream geometry
`define KPB_PAR_W        16
`define KPB_LANES        4
`define KPB_BEAT_W       64
`define KPB_KEEP_W       8

// kernel layout, 3x3 elements per channel
`define KPB_KERN_ELEMS   9

// slot ring
`define KPB_SLOTS        4
`define KPB_PRL          2   // slots handed out per group

// channel depth of every slot memory
`define KPB_MAX_CHN      16

`endif

// ==== kpb_pkg.sv ====
`default_nettype none

`include "kpb_config.svh"

package kpb_pkg;

	// kernel shape, 1x1 lands on the centre element
	typedef enum logic
	{
		KERNEL_1X1 = 1'b0,
		KERNEL_3X3 = 1'b1
	} kernel_type_e;

	// x1y1 in the low bits, x3y3 in the top bits
	typedef logic [`KPB_KERN_ELEMS*`KPB_PAR_W-1:0] kernel_word_t;

	// oldest slot in the low word
	typedef logic [`KPB_PRL*`KPB_KERN_ELEMS*`KPB_PAR_W-1:0] group_word_t;

	typedef logic [$clog2(`KPB_MAX_CHN)-1:0] chn_addr_t;
	typedef logic [$clog2(`KPB_SLOTS)-1:0] slot_idx_t;

endpackage

`default_nettype wire

// ==== kernel_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kpb_config.svh"

module kernel_assembler
	import kpb_pkg::*;
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire kernel_type_e       kernel_type_i,
	input  wire [`KPB_BEAT_W-1:0]   s_data_i,
	input  wire [`KPB_KEEP_W-1:0]   s_keep_i,
	input  wire                     s_last_i,
	input  wire                     s_user_i,
	input  wire                     s_valid_i,
	output logic                    s_ready_o,   // combinational
	input  wire                     wr_ready_i,
	output logic                    kw_valid_o,
	output kernel_word_t            kw_data_o,
	output chn_addr_t               kw_addr_o,
	output logic                    kw_last_o,
	output logic                    kw_user_o
);

	localparam int CNT_W = $clog2(`KPB_KERN_ELEMS);
	localparam int SR_N = `KPB_KERN_ELEMS - 1;
	localparam int CENTRE = `KPB_KERN_ELEMS / 2;   // x2y2
	localparam logic [`KPB_LANES-1:0] LANE0 = {{(`KPB_LANES-1){1'b0}}, 1'b1};

	logic [`KPB_PAR_W-1:0] lane_par [`KPB_LANES];
	logic [`KPB_LANES-1:0] keep_mask;
	logic [`KPB_LANES-1:0] lane_sel;       // one-hot, current lane
	logic [`KPB_LANES-1:0] lane_sel_nxt;
	logic [`KPB_PAR_W-1:0] cur_par;
	logic [`KPB_PAR_W-1:0] elem_sr [SR_N]; // earlier elements of the channel
	logic [CNT_W-1:0]      elem_cnt;
	logic                  is_3x3;
	logic                  advance;
	logic                  beat_end;
	logic                  kern_end;

	// split the beat into lanes, keep bit is the low byte of each lane
	for (genvar l = 0; l < `KPB_LANES; l++)
	begin : g_lane
		assign lane_par[l] = s_data_i[l*`KPB_PAR_W +: `KPB_PAR_W];
		assign keep_mask[l] = s_keep_i[l*`KPB_PAR_W/8];
	end

	always_comb
	begin
		cur_par = '0;
		for (int l = 0; l < `KPB_LANES; l++)
			cur_par = cur_par | (lane_par[l] & {`KPB_PAR_W{lane_sel[l]}});
	end

	assign lane_sel_nxt = {lane_sel[`KPB_LANES-2:0], lane_sel[`KPB_LANES-1]};

	// top lane, or a last beat with no kept lane above this one
	assign beat_end = lane_sel[`KPB_LANES-1] | (s_last_i & ~|(lane_sel_nxt & keep_mask));
	assign kern_end = s_last_i & beat_end;

	assign is_3x3 = kernel_type_i == KERNEL_3X3;
	assign advance = s_valid_i & wr_ready_i;

	assign s_ready_o = advance & beat_end;
	assign kw_valid_o = s_valid_i &
		(~is_3x3 | (elem_cnt == CNT_W'(SR_N)) | kern_end);
	assign kw_last_o = kern_end;
	assign kw_user_o = s_user_i;

	always_comb
	begin
		kw_data_o = '0;
		if (is_3x3)
		begin
			for (int e = 0; e < SR_N; e++)
				kw_data_o[e*`KPB_PAR_W +: `KPB_PAR_W] = elem_sr[e];
			kw_data_o[SR_N*`KPB_PAR_W +: `KPB_PAR_W] = cur_par;
		end
		else
		begin
			kw_data_o[CENTRE*`KPB_PAR_W +: `KPB_PAR_W] = cur_par;  // 1x1 at the centre
		end
	end

	// new element enters at the top, first one ends up at x1y1
	always_ff @(posedge clk)
	begin
		if (advance && is_3x3)
		begin
			for (int e = 0; e < SR_N - 1; e++)
				elem_sr[e] <= elem_sr[e+1];
			elem_sr[SR_N-1] <= cur_par;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lane_sel <= LANE0;
			elem_cnt <= '0;
			kw_addr_o <= '0;
		end
		else if (advance)
		begin
			lane_sel <= beat_end ? LANE0 : lane_sel_nxt;
			elem_cnt <= kw_valid_o ? '0 : elem_cnt + 1'b1;
			if (kw_valid_o)
				kw_addr_o <= kw_last_o ? '0 : kw_addr_o + 1'b1;  // next channel
		end
	end

	// lanes are packed from lane 0, so a valid beat always keeps lane 0
	a_keep_lane0: assert property (@(posedge clk) disable iff (!rst_n)
		s_valid_i |-> s_keep_i[0])
		else $error("valid beat without lane 0 kept");

endmodule

`default_nettype wire

// ==== slot_ring_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kpb_config.svh"

module slot_ring_ctrl
	import kpb_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    kw_valid_i,
	input  wire                    kw_last_i,
	input  wire                    kw_user_i,
	input  wire                    grp_release_i,
	output logic                   wr_ready_o,
	output logic [`KPB_SLOTS-1:0]  slot_wen_o,
	output slot_idx_t              slot_base_o,   // oldest occupied slot
	output logic [`KPB_SLOTS-1:0]  slot_vld_o,
	output logic                   grp_avail_o
);

	localparam int OCC_W = $clog2(`KPB_SLOTS + 1);
	localparam logic [`KPB_SLOTS-1:0] SLOT0 = {{(`KPB_SLOTS-1){1'b0}}, 1'b1};

	slot_idx_t        wr_ptr;
	logic [OCC_W-1:0] occ;
	logic [OCC_W-1:0] occ_nxt;
	logic             wr_fire;
	logic             commit;
	logic             release_ok;

	assign wr_ready_o = occ != OCC_W'(`KPB_SLOTS);
	assign grp_avail_o = occ >= OCC_W'(`KPB_PRL);

	assign wr_fire = kw_valid_i & wr_ready_o;    // any channel word
	assign commit = wr_fire & kw_last_i;         // kernel complete
	assign release_ok = grp_release_i & grp_avail_o;

	assign slot_wen_o = {`KPB_SLOTS{wr_fire}} & (SLOT0 << wr_ptr);

	always_comb
	begin
		occ_nxt = occ;
		if (commit)
			occ_nxt = occ_nxt + 1'b1;
		if (release_ok)
			occ_nxt = occ_nxt - OCC_W'(`KPB_PRL);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			occ <= '0;
			wr_ptr <= '0;
			slot_base_o <= '0;
		end
		else
		begin
			occ <= occ_nxt;
			if (commit)
				wr_ptr <= wr_ptr + 1'b1;   // wraps around the ring
			if (release_ok)
				slot_base_o <= slot_base_o + slot_idx_t'(`KPB_PRL);
		end
	end

	// user flag of the kernel taken at its last word
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			slot_vld_o <= '0;
		else if (commit)
			slot_vld_o[wr_ptr] <= kw_user_i;
	end

	// write pointer leads the base by the occupancy
	a_occ_ptr: assert property (@(posedge clk) disable iff (!rst_n)
		(occ <= OCC_W'(`KPB_SLOTS)) && (wr_ptr == slot_base_o + slot_idx_t'(occ)))
		else $error("slot occupancy out of step with the ring pointers");

endmodule

`default_nettype wire

// ==== kernel_slot_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kpb_config.svh"

module kernel_slot_mem
	import kpb_pkg::*;
(
	input  wire               clk,
	input  wire               wen_i,
	input  wire chn_addr_t    waddr_i,
	input  wire kernel_word_t wdata_i,
	input  wire               ren_i,
	input  wire chn_addr_t    raddr_i,
	output kernel_word_t      rdata_o
);

	kernel_word_t mem [`KPB_MAX_CHN];   // one word per channel

	always_ff @(posedge clk)
	begin
		if (wen_i)
			mem[waddr_i] <= wdata_i;
	end

	// registered read port
	always_ff @(posedge clk)
	begin
		if (ren_i)
			rdata_o <= mem[raddr_i];
	end

	// read-during-write on one address is not defined for the RAM
	a_no_rw_clash: assert property (@(posedge clk)
		!(wen_i && ren_i && (waddr_i == raddr_i)))
		else $error("read and write to the same channel in one cycle");

endmodule

`default_nettype wire

// ==== group_read_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kpb_config.svh"

module group_read_align
	import kpb_pkg::*;
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     rd_en_i,
	input  wire chn_addr_t          rd_addr_i,
	input  wire slot_idx_t          slot_base_i,
	input  wire [`KPB_SLOTS-1:0]    slot_vld_i,
	input  wire kernel_word_t       slot_rdata_i [`KPB_SLOTS],
	output logic                    slot_ren_o,
	output chn_addr_t               slot_raddr_o,
	output group_word_t             rd_data_o,
	output logic                    rd_vld_o
);

	localparam int KW = $bits(kernel_word_t);

	slot_idx_t             base_q;     // base taken with the request
	logic [`KPB_SLOTS-1:0] vld_q;
	logic                  req_q;      // memory data valid next to these
	kernel_word_t          masked [`KPB_SLOTS];
	group_word_t           grp_rot;

	// every slot memory sees the same request
	assign slot_ren_o = rd_en_i;
	assign slot_raddr_o = rd_addr_i;

	always_ff @(posedge clk)
	begin
		if (rd_en_i)
		begin
			base_q <= slot_base_i;
			vld_q <= slot_vld_i;
		end
	end

	// invalid slots read as zero
	for (genvar s = 0; s < `KPB_SLOTS; s++)
	begin : g_mask
		assign masked[s] = slot_rdata_i[s] & {KW{vld_q[s]}};
	end

	// oldest slot to lane 0, only the first KPB_PRL lanes are kept
	always_comb
	begin
		slot_idx_t idx;
		for (int j = 0; j < `KPB_PRL; j++)
		begin
			idx = base_q + slot_idx_t'(j);
			grp_rot[j*KW +: KW] = masked[idx];
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_q)
			rd_data_o <= grp_rot;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req_q <= 1'b0;
			rd_vld_o <= 1'b0;
		end
		else
		begin
			req_q <= rd_en_i;
			rd_vld_o <= req_q;   // two cycles after rd_en_i
		end
	end

endmodule

`default_nettype wire

// ==== axis_kernel_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kpb_config.svh"

module axis_kernel_buffer
	import kpb_pkg::*;
(
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire kernel_type_e       kernel_type_i,
	input  wire [`KPB_BEAT_W-1:0]   s_data_i,
	input  wire [`KPB_KEEP_W-1:0]   s_keep_i,
	input  wire                     s_last_i,
	input  wire                     s_user_i,
	input  wire                     s_valid_i,
	output logic                    s_ready_o,
	output logic                    grp_avail_o,
	input  wire                     grp_release_i,
	input  wire                     rd_en_i,
	input  wire chn_addr_t          rd_addr_i,
	output group_word_t             rd_data_o,
	output logic                    rd_vld_o
);

	logic                  kw_valid;
	kernel_word_t          kw_data;
	chn_addr_t             kw_addr;
	logic                  kw_last;
	logic                  kw_user;
	logic                  wr_ready;
	logic [`KPB_SLOTS-1:0] slot_wen;
	slot_idx_t             slot_base;
	logic [`KPB_SLOTS-1:0] slot_vld;
	logic                  slot_ren;
	chn_addr_t             slot_raddr;
	kernel_word_t          slot_rdata [`KPB_SLOTS];

	kernel_assembler i_assembler (
		.clk           (clk),
		.rst_n         (rst_n),
		.kernel_type_i (kernel_type_i),
		.s_data_i      (s_data_i),
		.s_keep_i      (s_keep_i),
		.s_last_i      (s_last_i),
		.s_user_i      (s_user_i),
		.s_valid_i     (s_valid_i),
		.s_ready_o     (s_ready_o),
		.wr_ready_i    (wr_ready),
		.kw_valid_o    (kw_valid),
		.kw_data_o     (kw_data),
		.kw_addr_o     (kw_addr),
		.kw_last_o     (kw_last),
		.kw_user_o     (kw_user)
	);

	slot_ring_ctrl i_ring (
		.clk           (clk),
		.rst_n         (rst_n),
		.kw_valid_i    (kw_valid),
		.kw_last_i     (kw_last),
		.kw_user_i     (kw_user),
		.grp_release_i (grp_release_i),
		.wr_ready_o    (wr_ready),
		.slot_wen_o    (slot_wen),
		.slot_base_o   (slot_base),
		.slot_vld_o    (slot_vld),
		.grp_avail_o   (grp_avail_o)
	);

	// one channel-addressed memory per slot
	for (genvar g = 0; g < `KPB_SLOTS; g++)
	begin : g_slot
		kernel_slot_mem i_mem (
			.clk     (clk),
			.wen_i   (slot_wen[g]),
			.waddr_i (kw_addr),
			.wdata_i (kw_data),
			.ren_i   (slot_ren),
			.raddr_i (slot_raddr),
			.rdata_o (slot_rdata[g])
		);
	end

	group_read_align i_reader (
		.clk          (clk),
		.rst_n        (rst_n),
		.rd_en_i      (rd_en_i),
		.rd_addr_i    (rd_addr_i),
		.slot_base_i  (slot_base),
		.slot_vld_i   (slot_vld),
		.slot_rdata_i (slot_rdata),
		.slot_ren_o   (slot_ren),
		.slot_raddr_o (slot_raddr),
		.rd_data_o    (rd_data_o),
		.rd_vld_o     (rd_vld_o)
	);

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
	output logic clk,
	output logic rst_n
);

	localparam real HALF_NS = 4.0;   // 8 ns period
	localparam int RST_CYC = 8;

	initial
	begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYC) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;   // released away from the rising edge
	end

endmodule

`default_nettype wire

// ==== tb_axis_kernel_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kpb_config.svh"

module tb_axis_kernel_buffer
	import kpb_pkg::*;
();

	localparam int CLK_NS = 8;
	localparam int KW = $bits(kernel_word_t);
	localparam int NUM_BEATS = 45;   // beats streamed over all tests
	localparam int NUM_READS = 16;
	localparam int STALL_CYC = 20;
	localparam int WDOG_CYC = 2 * (NUM_BEATS * `KPB_LANES + NUM_READS * 4 + STALL_CYC) + 200;

	logic                   clk;
	logic                   rst_n;
	kernel_type_e           kernel_type;
	logic [`KPB_BEAT_W-1:0] s_data;
	logic [`KPB_KEEP_W-1:0] s_keep;
	logic                   s_last;
	logic                   s_user;
	logic                   s_valid;
	logic                   s_ready;
	logic                   grp_avail;
	logic                   grp_release;
	logic                   rd_en;
	chn_addr_t              rd_addr;
	group_word_t            rd_data;
	logic                   rd_vld;

	// expected contents of the slot ring
	kernel_word_t          exp_word [`KPB_SLOTS][`KPB_MAX_CHN];
	logic                  exp_vld [`KPB_SLOTS];
	int                    model_wr;
	int                    model_base;
	int                    model_occ;
	logic [`KPB_PAR_W-1:0] par_q [$];   // parameters of the kernel being sent
	kernel_type_e          cur_type;
	logic                  cur_user;
	integer                seed;
	int                    errors;
	int                    tests_run;
	int                    tests_failed;

	tb_clk_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	axis_kernel_buffer i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.kernel_type_i (kernel_type),
		.s_data_i      (s_data),
		.s_keep_i      (s_keep),
		.s_last_i      (s_last),
		.s_user_i      (s_user),
		.s_valid_i     (s_valid),
		.s_ready_o     (s_ready),
		.grp_avail_o   (grp_avail),
		.grp_release_i (grp_release),
		.rd_en_i       (rd_en),
		.rd_addr_i     (rd_addr),
		.rd_data_o     (rd_data),
		.rd_vld_o      (rd_vld)
	);

	task automatic flag_mismatch(input string test, input string what,
		input group_word_t exp_v, input group_word_t act_v);
		$display("ERR %s %s expected %0h actual %0h", test, what, exp_v, act_v);
		errors++;
	endtask

	task automatic finish_test(input string test, input int err_before);
		tests_run++;
		if (errors != err_before)
			tests_failed++;
		$display("test %s done, %0d errors", test, errors - err_before);
	endtask

	// draw parameters and predict the channel words of the next slot
	task automatic build_kernel(input kernel_type_e kt, input int n_par, input logic user);
		logic [31:0] rnd;
		int c;
		int e;
		par_q.delete();
		for (int i = 0; i < n_par; i++)
		begin
			rnd = $random(seed);
			par_q.push_back(rnd[`KPB_PAR_W-1:0]);
		end
		for (int i = 0; i < n_par; i++)
		begin
			c = (kt == KERNEL_3X3) ? i / `KPB_KERN_ELEMS : i;
			e = (kt == KERNEL_3X3) ? i % `KPB_KERN_ELEMS : `KPB_KERN_ELEMS / 2;
			if (e == 0 || kt == KERNEL_1X1)
				exp_word[model_wr][c] = '0;
			exp_word[model_wr][c][e*`KPB_PAR_W +: `KPB_PAR_W] = par_q[i];
		end
		exp_vld[model_wr] = user;
		model_wr = (model_wr + 1) % `KPB_SLOTS;
		cur_type = kt;
		cur_user = user;
	endtask

	task automatic drive_beat(input int first, output int lanes);
		lanes = par_q.size() - first;
		if (lanes > `KPB_LANES)
			lanes = `KPB_LANES;
		s_data = '0;
		s_keep = '0;
		for (int l = 0; l < lanes; l++)
		begin
			s_data[l*`KPB_PAR_W +: `KPB_PAR_W] = par_q[first+l];
			s_keep[l*(`KPB_PAR_W/8) +: (`KPB_PAR_W/8)] = '1;   // all bytes of the lane
		end
		s_last = (first + lanes) == par_q.size();
		s_user = cur_user;
		kernel_type = cur_type;
		s_valid = 1'b1;
	endtask

	// ready is sampled mid low phase, the beat goes at the next rising edge
	task automatic wait_accept(output int cycles);
		logic hs;
		cycles = 0;
		hs = 1'b0;
		while (!hs)
		begin
			#1;
			hs = s_ready;
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic stream_kernel(input string test, input int first_par);
		int lanes;
		int cycles;
		for (int f = first_par; f < par_q.size(); f += `KPB_LANES)
		begin
			drive_beat(f, lanes);
			wait_accept(cycles);
			if (cycles != lanes)
				flag_mismatch(test, "cycles per beat", lanes, cycles);
		end
		s_valid = 1'b0;
		s_last = 1'b0;
		model_occ++;
		if (grp_avail !== (model_occ >= `KPB_PRL))
			flag_mismatch(test, "grp_avail_o after kernel", model_occ >= `KPB_PRL, grp_avail);
	endtask

	function automatic group_word_t expect_group(input int ch);
		group_word_t g;
		int s;
		g = '0;
		for (int j = 0; j < `KPB_PRL; j++)
		begin
			s = (model_base + j) % `KPB_SLOTS;
			if (exp_vld[s])
				g[j*KW +: KW] = exp_word[s][ch];
		end
		return g;
	endfunction

	// back-to-back requests, each answer due two cycles later
	task automatic read_group(input string test, input int n_ch);
		logic vld_exp;
		for (int i = 0; i <= n_ch + 2; i++)
		begin
			vld_exp = (i >= 2) && (i < n_ch + 2);
			if (rd_vld !== vld_exp)
				flag_mismatch(test, "rd_vld_o", vld_exp, rd_vld);
			else if (vld_exp && rd_data !== expect_group(i - 2))
				flag_mismatch(test, $sformatf("rd_data_o chn %0d", i - 2),
					expect_group(i - 2), rd_data);
			rd_en = i < n_ch;
			rd_addr = chn_addr_t'(i);
			@(negedge clk);
		end
		rd_en = 1'b0;
	endtask

	task automatic release_group(input string test);
		if (grp_avail !== 1'b1)
			flag_mismatch(test, "grp_avail_o before release", 1, grp_avail);
		grp_release = 1'b1;
		@(negedge clk);
		grp_release = 1'b0;
		model_base = (model_base + `KPB_PRL) % `KPB_SLOTS;
		model_occ -= `KPB_PRL;
		if (grp_avail !== (model_occ >= `KPB_PRL))
			flag_mismatch(test, "grp_avail_o after release", model_occ >= `KPB_PRL, grp_avail);
	endtask

	task automatic test_reset_idle();
		int e0;
		e0 = errors;
		repeat (2) @(negedge clk);
		if (s_ready !== 1'b0)
			flag_mismatch("reset_idle", "s_ready_o", 0, s_ready);
		if (grp_avail !== 1'b0)
			flag_mismatch("reset_idle", "grp_avail_o", 0, grp_avail);
		if (rd_vld !== 1'b0)
			flag_mismatch("reset_idle", "rd_vld_o", 0, rd_vld);
		finish_test("reset_idle", e0);
	endtask

	task automatic test_pair_3x3();
		int e0;
		e0 = errors;
		for (int k = 0; k < `KPB_PRL; k++)
		begin
			build_kernel(KERNEL_3X3, 3 * `KPB_KERN_ELEMS, 1'b1);   // three channels
			stream_kernel("pair_3x3", 0);
		end
		read_group("pair_3x3", 3);
		release_group("pair_3x3");
		finish_test("pair_3x3", e0);
	endtask

	task automatic test_partial_1x1();
		int e0;
		e0 = errors;
		for (int k = 0; k < `KPB_PRL; k++)
		begin
			build_kernel(KERNEL_1X1, 10, 1'b1);   // last beat keeps two lanes
			stream_kernel("partial_1x1", 0);
		end
		read_group("partial_1x1", 10);
		release_group("partial_1x1");
		finish_test("partial_1x1", e0);
	endtask

	task automatic test_user_masked();
		int e0;
		e0 = errors;
		build_kernel(KERNEL_3X3, 2 * `KPB_KERN_ELEMS, 1'b0);
		stream_kernel("user_masked", 0);
		build_kernel(KERNEL_3X3, 2 * `KPB_KERN_ELEMS, 1'b1);
		stream_kernel("user_masked", 0);
		read_group("user_masked", 2);
		release_group("user_masked");
		finish_test("user_masked", e0);
	endtask

	task automatic test_full_stall();
		int e0;
		int lanes;
		int cycles;
		e0 = errors;
		for (int k = 0; k < `KPB_SLOTS; k++)
		begin
			build_kernel(KERNEL_3X3, `KPB_KERN_ELEMS, 1'b1);
			stream_kernel("full_stall", 0);
		end
		build_kernel(KERNEL_3X3, `KPB_KERN_ELEMS, 1'b1);
		drive_beat(0, lanes);
		repeat (STALL_CYC)
		begin
			#1;
			if (s_ready !== 1'b0)
				flag_mismatch("full_stall", "s_ready_o with ring full", 0, s_ready);
			@(negedge clk);
		end
		release_group("full_stall");
		wait_accept(cycles);
		if (cycles != lanes)
			flag_mismatch("full_stall", "cycles for held beat", lanes, cycles);
		stream_kernel("full_stall", `KPB_LANES);
		read_group("full_stall", 1);   // third and fourth kernels of the fill
		release_group("full_stall");
		finish_test("full_stall", e0);
	endtask

	initial
	begin
		seed = 32'h9088c53a;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		model_wr = 0;
		model_base = 0;
		model_occ = 0;
		for (int s = 0; s < `KPB_SLOTS; s++)
			exp_vld[s] = 1'b0;
		cur_type = KERNEL_3X3;
		cur_user = 1'b0;
		kernel_type = KERNEL_3X3;
		s_data = '0;
		s_keep = '0;
		s_last = 1'b0;
		s_user = 1'b0;
		s_valid = 1'b0;
		grp_release = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		wait (rst_n === 1'b1);
		@(negedge clk);
		test_reset_idle();
		test_pair_3x3();
		test_partial_1x1();
		test_user_masked();
		test_full_stall();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// bound on the whole run
	initial
	begin
		#(WDOG_CYC * CLK_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== axis_kernel_buffer.f ====
+incdir+.
kpb_pkg.sv
kernel_assembler.sv
slot_ring_ctrl.sv
kernel_slot_mem.sv
group_read_align.sv
axis_kernel_buffer.sv
tb_clk_gen.sv
tb_axis_kernel_buffer.sv

// ==== Bender.yml ====
package:
  name: axis_kernel_buffer

export_include_dirs:
  - .

sources:
  - files:
      - kpb_pkg.sv
      - kernel_assembler.sv
      - slot_ring_ctrl.sv
      - kernel_slot_mem.sv
      - group_read_align.sv
      - axis_kernel_buffer.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_axis_kernel_buffer.sv
